// File: rtl/lzc_16.sv
//**************************************************************************
// out_z is only meaningful while v is high; a zero input gives v low
//**************************************************************************
`timescale 1ns/1ps

module lzc_16 (
  input  logic [15:0] in,
  output logic        v,
  output logic [3:0]  out_z
);

  // per-nibble valid and zero count
  logic [3:0] grp_v;
  logic [1:0] grp_z [4];
  logic [1:0] sel;

  // leading zeros of a 4-bit value, don't care when all zero
  function automatic logic [1:0] nlz4(input logic [3:0] x);
    nlz4[1] = ~(x[3] | x[2]);
    nlz4[0] = ~(x[3] | (~x[2] & x[1]));
  endfunction

  // first level, group 3 holds the top nibble
  always_comb begin
    for (int g = 0; g < 4; g++) begin
      grp_v[g] = |in[4*g +: 4];
      grp_z[g] = nlz4(in[4*g +: 4]);
    end
  end

  // second level, same nibble logic applied to the group valids
  assign sel = nlz4(grp_v);
  assign v   = |grp_v;

  // group index gives the upper bits, that group's count the lower
  assign out_z = {sel, grp_z[2'd3 - sel]};

endmodule

// File: rtl/range_enc_pkg.sv
//**************************************************************************
// sizes are fixed by the 16-bit LZC; low has no carry handling and wraps
//**************************************************************************
package range_enc_pkg;

  // datapath widths
  localparam int RANGE_WIDTH  = 16;
  localparam int D_SIZE       = 5;
  localparam int SYMBOL_WIDTH = 4;
  localparam int NSYMS_WIDTH  = 5;
  localparam int LOW_WIDTH    = 32;
  localparam int BITS_WIDTH   = 32;

  // reset range and Q15 probability one
  localparam logic [RANGE_WIDTH-1:0] RANGE_INIT = 16'd32768;
  localparam logic [RANGE_WIDTH-1:0] CDF_ONE    = 16'd32768;

  // scaling of the range update
  // rr = range >> 8, cdf operands drop 6 bits, product drops 1 more
  localparam int RR_SHIFT   = 8;
  localparam int PROB_SHIFT = 6;
  localparam int MUL_SHIFT  = 1;
  // bool prob is fixed at one half, (rr * 256) >> 1 == rr << 7
  localparam int BOOL_SHIFT = 7;
  // minimum probability per remaining symbol
  localparam logic [RANGE_WIDTH-1:0] MIN_PROB = 16'd4;

  // symbol request as captured by the front end
  typedef struct packed {
    logic [RANGE_WIDTH-1:0]  fl;
    logic [RANGE_WIDTH-1:0]  fh;
    logic [SYMBOL_WIDTH-1:0] symbol;
    logic [NSYMS_WIDTH-1:0]  nsyms;
    logic                    bool_flag;
  } enc_req_t;

  // scaled operands from stage 1
  typedef struct packed {
    logic [RANGE_WIDTH-1:0]  uu;
    logic [RANGE_WIDTH-1:0]  vv;
    logic [RANGE_WIDTH-1:0]  lut_u;
    logic [RANGE_WIDTH-1:0]  lut_v;
    // fl below CDF_ONE
    logic                    comp;
    logic [SYMBOL_WIDTH-1:0] symbol;
    logic                    bool_flag;
  } s1_out_t;

  // range update result from stage 2
  typedef struct packed {
    logic [RANGE_WIDTH:0]   u;
    logic [RANGE_WIDTH:0]   v_bool;
    logic [RANGE_WIDTH-1:0] initial_range;
    logic [RANGE_WIDTH-1:0] out_range;
    logic [D_SIZE-1:0]      d;
    // [1] bool flag, [0] symbol lsb
    logic [1:0]             bool_symbol;
    logic                   comp;
  } s2_out_t;

  // encoder state after each symbol
  typedef struct packed {
    logic [RANGE_WIDTH-1:0] range;
    logic [LOW_WIDTH-1:0]   low;
    logic [D_SIZE-1:0]      d;
    logic [BITS_WIDTH-1:0]  bits;
  } enc_out_t;

endpackage

// File: rtl/range_enc_stage_1.sv
//**************************************************************************
// symbol must be below nsyms on cdf requests; nsyms is ignored for bool
//**************************************************************************
`timescale 1ns/1ps

module range_enc_stage_1
  import range_enc_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     valid,
  input  enc_req_t req,
  output logic     s1_valid,
  output s1_out_t  s1
);

  // symbols still above s, i.e. N - s + 1
  logic [RANGE_WIDTH-1:0] syms_above;
  s1_out_t                s1_d;

  assign syms_above = RANGE_WIDTH'(req.nsyms) - RANGE_WIDTH'(req.symbol);

  always_comb begin
    // inverse cdf bounds down to 10 bits
    s1_d.uu = req.fl >> PROB_SHIFT;
    s1_d.vv = req.fh >> PROB_SHIFT;
    // min prob offset for the lower bound, 4 * (N - s + 1)
    s1_d.lut_u = MIN_PROB * syms_above;
    // and for the upper bound, 4 * (N - s)
    s1_d.lut_v = MIN_PROB * (syms_above - RANGE_WIDTH'(1));
    // symbol 0 carries fl == one
    s1_d.comp = req.fl < CDF_ONE;
    s1_d.symbol    = req.symbol;
    s1_d.bool_flag = req.bool_flag;
  end

  // valid pulse follows the front end by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= valid;
    end
  end

  // operands only load with a request
  always_ff @(posedge clk) begin
    if (valid) begin
      s1 <= s1_d;
    end
  end

  // out of range symbol would wrap the lut offsets
  a_symbol_in_range: assert property (
    @(posedge clk) disable iff (reset)
    valid && !req.bool_flag |-> NSYMS_WIDTH'(req.symbol) < req.nsyms
  ) else $error("stage 1: symbol %0d not below nsyms %0d", req.symbol, req.nsyms);

endmodule

// File: rtl/range_enc_stage_2.sv
//**************************************************************************
// state_range must be current when s1_valid is high; one symbol in flight
//**************************************************************************
`timescale 1ns/1ps

module range_enc_stage_2
  import range_enc_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   s1_valid,
  input  s1_out_t                s1,
  input  logic [RANGE_WIDTH-1:0] state_range,
  output logic                   s2_valid,
  output s2_out_t                s2
);

  logic [RANGE_WIDTH-1:0]   rr;
  logic [2*RANGE_WIDTH-1:0] prod_u;
  logic [2*RANGE_WIDTH-1:0] prod_v;
  logic [RANGE_WIDTH:0]     u;
  logic [RANGE_WIDTH:0]     v;
  logic [RANGE_WIDTH:0]     v_bool;
  logic [RANGE_WIDTH-1:0]   range_cdf;
  logic [RANGE_WIDTH-1:0]   range_bool;
  logic [RANGE_WIDTH-1:0]   range_raw;
  logic [RANGE_WIDTH-1:0]   range_norm;
  logic [D_SIZE-2:0]        lz;
  logic                     lzc_v;
  s2_out_t                  s2_d;

  // top 8 bits of the range
  assign rr = state_range >> RR_SHIFT;

  // cdf path
  // u = ((rr * uu) >> 1) + 4 * (N - s + 1)
  // v = ((rr * vv) >> 1) + 4 * (N - s)
  assign prod_u = rr * s1.uu;
  assign prod_v = rr * s1.vv;
  assign u = (RANGE_WIDTH+1)'(prod_u >> MUL_SHIFT) + (RANGE_WIDTH+1)'(s1.lut_u);
  assign v = (RANGE_WIDTH+1)'(prod_v >> MUL_SHIFT) + (RANGE_WIDTH+1)'(s1.lut_v);

  // without comp the lower bound is the full range
  assign range_cdf = s1.comp ? u[RANGE_WIDTH-1:0] - v[RANGE_WIDTH-1:0]
                             : state_range - v[RANGE_WIDTH-1:0];

  // bool path, fixed half probability
  assign v_bool = ((RANGE_WIDTH+1)'(rr) << BOOL_SHIFT) + (RANGE_WIDTH+1)'(MIN_PROB);

  // bit 1 keeps the v part, bit 0 the remainder
  assign range_bool = s1.symbol[0] ? v_bool[RANGE_WIDTH-1:0]
                                   : state_range - v_bool[RANGE_WIDTH-1:0];

  // range before renormalization
  assign range_raw = s1.bool_flag ? range_bool : range_cdf;

  // one-round renormalization
  // shift by the leading zeros so the msb lands on top
  lzc_16 u_lzc (
    .in    (range_raw),
    .v     (lzc_v),
    .out_z (lz)
  );

  assign range_norm = range_raw << lz;

  always_comb begin
    s2_d.u             = u;
    s2_d.v_bool        = v_bool;
    s2_d.initial_range = state_range;
    s2_d.out_range     = range_norm;
    s2_d.d             = {1'b0, lz};
    s2_d.bool_symbol   = {s1.bool_flag, s1.symbol[0]};
    s2_d.comp          = s1.comp;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2 <= s2_d;
    end
  end

  // a zero range means bad cdf bounds upstream or a stale state range
  a_range_nonzero: assert property (
    @(posedge clk) disable iff (reset)
    s1_valid |-> lzc_v
  ) else $error("stage 2: raw range is zero, state range %h", state_range);

endmodule

// File: rtl/range_enc_stage_3.sv
//**************************************************************************
// low wraps at LOW_WIDTH bits; carries out of low are dropped, no byte output
//**************************************************************************
`timescale 1ns/1ps

module range_enc_stage_3
  import range_enc_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   s2_valid,
  input  s2_out_t                s2,
  output logic [RANGE_WIDTH-1:0] state_range,
  output logic                   out_valid,
  output enc_out_t               out_data
);

  // encoder state
  logic [RANGE_WIDTH-1:0] range_q;
  logic [LOW_WIDTH-1:0]   low_q;
  logic [BITS_WIDTH-1:0]  bits_q;
  // shift of the last symbol, result only
  logic [D_SIZE-1:0]      d_q;

  logic [RANGE_WIDTH-1:0] low_inc;
  logic [LOW_WIDTH-1:0]   low_sum;
  logic [LOW_WIDTH-1:0]   low_next;

  // low moves up by the part of the range below the coded interval
  always_comb begin
    low_inc = '0;
    if (s2.bool_symbol[1]) begin
      // bool, only a one skips the lower part
      if (s2.bool_symbol[0]) begin
        low_inc = s2.initial_range - s2.v_bool[RANGE_WIDTH-1:0];
      end
    end else if (s2.comp) begin
      // cdf symbol other than 0
      low_inc = s2.initial_range - s2.u[RANGE_WIDTH-1:0];
    end
  end

  // add then renormalize, upper bits fall off
  assign low_sum  = low_q + LOW_WIDTH'(low_inc);
  assign low_next = low_sum << s2.d;

  always_ff @(posedge clk) begin
    if (reset) begin
      range_q   <= RANGE_INIT;
      low_q     <= '0;
      bits_q    <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= s2_valid;
      if (s2_valid) begin
        range_q <= s2.out_range;
        low_q   <= low_next;
        // running total of renorm shifts
        bits_q  <= bits_q + BITS_WIDTH'(s2.d);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      d_q <= s2.d;
    end
  end

  // feedback to stage 2
  assign state_range = range_q;

  // result holds between symbols since state only moves on s2_valid
  assign out_data = '{
    range: range_q,
    low:   low_q,
    d:     d_q,
    bits:  bits_q
  };

  // renormalized range keeps its msb set
  a_range_normalized: assert property (
    @(posedge clk) disable iff (reset)
    range_q[RANGE_WIDTH-1]
  ) else $error("stage 3: range %h lost its top bit", range_q);

endmodule

// File: rtl/range_enc_top.sv
//**************************************************************************
// four-phase req/ack input, one symbol in flight; no output back-pressure
//**************************************************************************
`timescale 1ns/1ps

module range_enc_top
  import range_enc_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     in_req,
  input  enc_req_t in_data,
  output logic     in_ack,
  output logic     out_valid,
  output enc_out_t out_data
);

  // front end
  logic     capture;
  logic     cap_valid;
  enc_req_t req_q;

  // stage chain
  logic                   s1_valid;
  s1_out_t                s1;
  logic                   s2_valid;
  s2_out_t                s2;
  logic [RANGE_WIDTH-1:0] state_range;

  // first edge with req high and ack low
  assign capture = in_req && !in_ack;

  // ack rises on capture and drops on the first edge with req low
  always_ff @(posedge clk) begin
    if (reset) begin
      in_ack    <= 1'b0;
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= capture;
      if (capture) begin
        in_ack <= 1'b1;
      end else if (!in_req && in_ack) begin
        in_ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      req_q <= in_data;
    end
  end

  range_enc_stage_1 u_stage_1 (
    .clk      (clk),
    .reset    (reset),
    .valid    (cap_valid),
    .req      (req_q),
    .s1_valid (s1_valid),
    .s1       (s1)
  );

  // state_range comes back from stage 3
  range_enc_stage_2 u_stage_2 (
    .clk         (clk),
    .reset       (reset),
    .s1_valid    (s1_valid),
    .s1          (s1),
    .state_range (state_range),
    .s2_valid    (s2_valid),
    .s2          (s2)
  );

  range_enc_stage_3 u_stage_3 (
    .clk         (clk),
    .reset       (reset),
    .s2_valid    (s2_valid),
    .s2          (s2),
    .state_range (state_range),
    .out_valid   (out_valid),
    .out_data    (out_data)
  );

  // source must hold req until it has seen ack
  a_req_held: assert property (
    @(posedge clk) disable iff (reset)
    in_req && !in_ack |=> in_req
  ) else $error("top: req dropped before ack");

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run tb_range_enc with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_range_enc -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Simulation finished: PASS$"; then
  exit 0
fi
echo "pass message not found"
exit 1

// File: sources.f
+incdir+test
rtl/range_enc_pkg.sv
rtl/lzc_16.sv
rtl/range_enc_stage_1.sv
rtl/range_enc_stage_2.sv
rtl/range_enc_stage_3.sv
rtl/range_enc_top.sv
test/tb_range_enc.sv

// File: test/range_enc_model.svh
//**************************************************************************
// model of one symbol step; low wraps at 32 bits, carries are not modeled
//**************************************************************************
`ifndef RANGE_ENC_MODEL_SVH
`define RANGE_ENC_MODEL_SVH

// leading zeros of a 16-bit value
function automatic int model_lzc(input int x);
  int n;
  n = 0;
  while (n < 16 && !x[15-n]) begin
    n++;
  end
  return n;
endfunction

// next encoder state after one symbol
function automatic enc_out_t model_step(input enc_out_t st, input enc_req_t rq);
  enc_out_t nx;
  int nn;
  int sym;
  int rng;
  int rr;
  int u;
  int v;
  int vb;
  int raw;
  int inc;
  int d;
  nn  = int'(rq.nsyms) - 1;
  sym = int'(rq.symbol);
  rng = int'(st.range);
  rr  = rng >> 8;
  // cdf bounds scaled to 10 bits, plus the minimum probability terms
  u  = ((rr * (int'(rq.fl) >> 6)) >> 1) + 4 * (nn - sym + 1);
  v  = ((rr * (int'(rq.fh) >> 6)) >> 1) + 4 * (nn - sym);
  // bool split sits at one half
  vb = rr * 128 + 4;
  if (rq.bool_flag) begin
    raw = rq.symbol[0] ? vb : rng - vb;
    inc = rq.symbol[0] ? rng - vb : 0;
  end else if (int'(rq.fl) < 32768) begin
    raw = u - v;
    inc = rng - u;
  end else begin
    // symbol 0, lower bound is the full range
    raw = rng - v;
    inc = 0;
  end
  d = model_lzc(raw);
  nx.range = RANGE_WIDTH'(raw << d);
  nx.low   = (st.low + LOW_WIDTH'(inc)) << d;
  nx.d     = D_SIZE'(d);
  nx.bits  = st.bits + BITS_WIDTH'(d);
  return nx;
endfunction

`endif

// File: test/tb_range_enc.sv
//**************************************************************************
// random symbols from seed 72 over four-phase req/ack, checked at negedge
//**************************************************************************
`timescale 1ns/1ps

module tb_range_enc
  import range_enc_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int NUM_SYMS   = 401;
  localparam int WATCHDOG_CYCLES = NUM_SYMS * 40 + 100;

  logic     clk = 1'b0;
  logic     reset = 1'b1;
  logic     in_req = 1'b0;
  enc_req_t in_data = '0;
  logic     in_ack;
  logic     out_valid;
  enc_out_t out_data;

  integer   seed = 72;
  int       err [1:5] = '{default: 0};
  int       phase = 1;
  int       cycle = 0;
  int       ack_rise_cycle = 0;
  int       pending = 0;
  logic     ack_prev = 1'b0;
  int       zero_syms = 0;
  int       bool_ones = 0;
  int       bool_zeros = 0;
  enc_out_t model_state = '{range: RANGE_INIT, low: '0, d: '0, bits: '0};
  enc_out_t exp_q [$];
  enc_out_t exp_v;

  `include "range_enc_model.svh"

  range_enc_top u_dut (
    .clk       (clk),
    .reset     (reset),
    .in_req    (in_req),
    .in_data   (in_data),
    .in_ack    (in_ack),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input int cat);
    assert (got == exp) else begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      err[cat]++;
    end
  endtask

  // random request, cdf bounds drawn as a strictly decreasing icdf
  function automatic enc_req_t make_request(input logic is_bool);
    enc_req_t rq;
    int n;
    int s;
    int prev;
    int lim;
    int icdf [16];
    rq = '0;
    rq.bool_flag = is_bool;
    if (is_bool) begin
      rq.nsyms  = NSYMS_WIDTH'(2);
      rq.symbol = SYMBOL_WIDTH'($unsigned($random(seed)) % 2);
      return rq;
    end
    n = 2 + int'($unsigned($random(seed)) % 15);
    s = int'($unsigned($random(seed)) % n);
    prev = 32768;
    for (int i = 0; i < n - 1; i++) begin
      // leave room for the symbols still below
      lim = n - 1 - i;
      icdf[i] = lim + int'($unsigned($random(seed)) % (prev - lim));
      prev = icdf[i];
    end
    icdf[n-1] = 0;
    rq.nsyms  = NSYMS_WIDTH'(n);
    rq.symbol = SYMBOL_WIDTH'(s);
    rq.fl = (s == 0) ? CDF_ONE : RANGE_WIDTH'(icdf[s-1]);
    rq.fh = RANGE_WIDTH'(icdf[s]);
    return rq;
  endfunction

  // one full four-phase cycle after a random idle gap
  task automatic send_symbol(input logic is_bool);
    enc_req_t rq;
    int gap;
    gap = int'($unsigned($random(seed)) % 6);
    rq = make_request(is_bool);
    if (!is_bool && rq.fl == CDF_ONE) zero_syms++;
    if (is_bool && rq.symbol[0]) bool_ones++;
    if (is_bool && !rq.symbol[0]) bool_zeros++;
    // always start on a rising edge
    repeat (gap + 1) @(posedge clk);
    model_state = model_step(model_state, rq);
    exp_q.push_back(model_state);
    in_data <= rq;
    in_req  <= 1'b1;
    @(posedge clk);
    while (!in_ack) @(posedge clk);
    in_req <= 1'b0;
    @(posedge clk);
    while (in_ack) @(posedge clk);
  endtask

  // wait for the last result, then report
  task automatic finish_test(input int num, input string name);
    while (exp_q.size() != 0 || pending != 0) @(negedge clk);
    @(negedge clk);
    $display("test %0d %s: %s, %0d errors", num, name, (err[num] == 0) ? "ok" : "failed",
             err[num]);
  endtask

  // handshake, latency and result checks, stable at negedge
  always @(negedge clk) begin
    if (!reset) begin
      if (in_ack && !ack_prev) begin
        assert (in_req) else begin
          $display("ack rose while req was low");
          err[5]++;
        end
        ack_rise_cycle = cycle;
        pending++;
      end
      if (!in_ack && ack_prev) begin
        assert (!in_req) else begin
          $display("ack fell while req was still high");
          err[5]++;
        end
      end
      if (out_valid) begin
        assert (pending > 0 && cycle == ack_rise_cycle + 3) else begin
          $display("out_valid at cycle %0d without a request 3 cycles before", cycle);
          err[5]++;
        end
        if (pending > 0) pending--;
        if (exp_q.size() == 0) begin
          $display("out_valid with no symbol outstanding");
          err[5]++;
        end else begin
          exp_v = exp_q.pop_front();
          check_value("out_data.range", 32'(out_data.range), 32'(exp_v.range), phase);
          check_value("out_data.low", out_data.low, exp_v.low, phase);
          check_value("out_data.d", 32'(out_data.d), 32'(exp_v.d), 4);
          check_value("out_data.bits", out_data.bits, exp_v.bits, 4);
          check_value("out_data.range[15]", 32'(out_data.range[15]), 32'd1, 4);
        end
      end
      ack_prev = in_ack;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: no finish after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int total;
    int failed;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("in_ack", 32'(in_ack), 32'd0, 1);
    check_value("out_valid", 32'(out_valid), 32'd0, 1);
    // first result builds on the reset state
    send_symbol(1'b0);
    finish_test(1, "reset values");
    phase = 2;
    repeat (200) send_symbol(1'b0);
    finish_test(2, "cdf symbols");
    assert (zero_syms > 0) else begin
      $display("no cdf symbol 0 was sent, comp clear not covered");
      err[2]++;
    end
    phase = 3;
    repeat (200) send_symbol(1'b1);
    finish_test(3, "bool symbols");
    assert (bool_ones > 0 && bool_zeros > 0) else begin
      $display("bool symbols did not cover both bit values");
      err[3]++;
    end
    finish_test(4, "shift and bit count");
    finish_test(5, "handshake and latency");
    total  = 0;
    failed = 0;
    for (int i = 1; i <= 5; i++) begin
      total += err[i];
      if (err[i] != 0) failed++;
    end
    $display("5 tests, %0d passed, %0d failed, %0d errors", 5 - failed, failed, total);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
